// File: Makefile
# Verilator build for the ROS 2 application node testbench

VERILATOR ?= verilator
TOP       ?= tb_ros2_app
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: app_cfg_regs.sv
// AXI4-Lite register slave with control, period, status
// and a read window over the subscriber buffer
`timescale 1ns/1ns

module app_cfg_regs import ros2_app_pkg::*; #(
    parameter logic [31:0] DEFAULT_PERIOD = 32'd1_000_000
) (
    input  logic        clk_int,
    input  logic        rst_n,
    input  axil_req_t   axil_req,
    output axil_rsp_t   axil_rsp,
    output app_cfg_t    cfg,
    input  app_status_t status,
    output logic [3:0]  buf_raddr,
    input  logic [31:0] buf_rdata
);

    logic        wr_rdy;
    logic        bvalid;
    logic        ar_rdy;
    logic        buf_wait;
    logic        rvalid;
    logic [31:0] rdata;
    logic [31:0] reg_rdata;
    logic [7:0]  aw_word;
    logic [7:0]  ar_word;
    logic        ar_in_buf;
    logic        wr_go;
    logic        rd_go;

    assign aw_word   = {axil_req.awaddr[7:2], 2'b00};
    assign ar_word   = {axil_req.araddr[7:2], 2'b00};
    assign ar_in_buf = (axil_req.araddr[7:6] == BUF_BASE[7:6]);
    assign buf_raddr = axil_req.araddr[5:2];

    // Accept address and data together, one transaction at a time
    assign wr_go = axil_req.awvalid && axil_req.wvalid && !wr_rdy && !bvalid;
    assign rd_go = axil_req.arvalid && !ar_rdy && !buf_wait && !rvalid;

    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            wr_rdy     <= 1'b0;
            bvalid     <= 1'b0;
            cfg.pub_en <= 1'b0;
            cfg.sub_en <= 1'b0;
            cfg.period <= DEFAULT_PERIOD;
        end else begin
            wr_rdy <= wr_go;
            if (wr_rdy) begin
                bvalid <= 1'b1;
                case (aw_word)
                    REG_CTRL: begin
                        if (axil_req.wstrb[0]) begin
                            cfg.pub_en <= axil_req.wdata[0];
                            cfg.sub_en <= axil_req.wdata[1];
                        end
                    end
                    REG_PERIOD: begin
                        for (int b = 0; b < 4; b++) begin
                            if (axil_req.wstrb[b]) begin
                                cfg.period[8*b +: 8] <= axil_req.wdata[8*b +: 8];
                            end
                        end
                    end
                    default: ;
                endcase
            end else if (bvalid && axil_req.bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        case (ar_word)
            REG_CTRL:    reg_rdata = {30'd0, cfg.sub_en, cfg.pub_en};
            REG_PERIOD:  reg_rdata = cfg.period;
            REG_STATUS:  reg_rdata = {status.sub_count, status.pub_count};
            REG_SUB_LEN: reg_rdata = {24'd0, status.sub_len};
            default:     reg_rdata = 32'd0;
        endcase
    end

    // Buffer reads wait one extra cycle for the RAM
    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            ar_rdy   <= 1'b0;
            buf_wait <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            ar_rdy <= rd_go;
            if (ar_rdy) begin
                if (ar_in_buf) begin
                    buf_wait <= 1'b1;
                end else begin
                    rvalid <= 1'b1;
                end
            end else if (buf_wait) begin
                buf_wait <= 1'b0;
                rvalid   <= 1'b1;
            end else if (rvalid && axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_int) begin
        if (ar_rdy && !ar_in_buf) begin
            rdata <= reg_rdata;
        end else if (buf_wait) begin
            rdata <= buf_rdata;
        end
    end

    always_comb begin
        axil_rsp.awready = wr_rdy;
        axil_rsp.wready  = wr_rdy;
        axil_rsp.bresp   = AXI_RESP_OKAY;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.arready = ar_rdy;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = AXI_RESP_OKAY;
        axil_rsp.rvalid  = rvalid;
    end

    a_bvalid_hold: assert property (@(posedge clk_int) disable iff (!rst_n)
        bvalid && !axil_req.bready |=> bvalid);

endmodule

// File: app_ctrl.sv
// Publish timer with req/grant/rel sequencing, subscriber gate
// and the status counters
`timescale 1ns/1ns

module app_ctrl import ros2_app_pkg::*; (
    input  logic        clk_int,
    input  logic        rst_n,
    input  app_cfg_t    cfg,
    input  logic        pub_grant,
    output logic        pub_req,
    output logic        pub_rel,
    output logic        advance,
    input  logic        sub_recv,
    input  logic [7:0]  sub_len,
    output logic        sub_open,
    output app_status_t status
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_REL
    } state_t;

    state_t      state;
    logic [31:0] tmr;
    logic        tmr_loaded;
    logic [15:0] pub_cnt;
    logic [15:0] sub_cnt;
    logic [7:0]  sub_len_q;

    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            tmr        <= 32'd0;
            tmr_loaded <= 1'b0;
            pub_cnt    <= 16'd0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // First period starts once reset has gone
                    if (!tmr_loaded) begin
                        tmr        <= cfg.period;
                        tmr_loaded <= 1'b1;
                    end else if (tmr != 32'd0) begin
                        tmr <= tmr - 32'd1;
                    end else if (cfg.pub_en) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (pub_grant) begin
                        state <= ST_REL;
                    end
                end
                ST_REL: begin
                    state   <= ST_IDLE;
                    tmr     <= cfg.period;
                    pub_cnt <= pub_cnt + 16'd1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign pub_req = (state == ST_REQ);
    assign pub_rel = (state == ST_REL);
    assign advance = pub_rel;

    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            sub_open  <= 1'b0;
            sub_cnt   <= 16'd0;
            sub_len_q <= 8'd0;
        end else begin
            sub_open <= cfg.sub_en;
            if (sub_recv && sub_open) begin
                sub_cnt   <= sub_cnt + 16'd1;
                sub_len_q <= sub_len;
            end
        end
    end

    assign status = '{pub_count: pub_cnt, sub_count: sub_cnt, sub_len: sub_len_q};

    // Grant sampled high ends the request with a single release
    a_grant_rel: assert property (@(posedge clk_int) disable iff (!rst_n)
        pub_req && pub_grant |=> pub_rel && !pub_req ##1 !pub_rel);

endmodule

// File: filelist.f
ros2_app_pkg.sv
reset_sync.sv
app_cfg_regs.sv
app_ctrl.sv
pub_msg_gen.sv
sub_msg_buffer.sv
ros2_app_top.sv
tb_ros2_app.sv

// File: pub_msg_gen.sv
// Publisher payload builder with the wrapping ASCII message digit
`timescale 1ns/1ns

module pub_msg_gen import ros2_app_pkg::*; (
    input  logic     clk_int,
    input  logic     rst_n,
    input  logic     advance,
    output pub_msg_t pub_msg
);

    localparam int TEXT_BYTE  = 4;
    localparam int DIGIT_BYTE = TEXT_BYTE + PUB_TEXT_LEN;

    localparam logic [7:0] DIGIT_FIRST = "0";
    localparam logic [7:0] DIGIT_LAST  = "9";

    logic [7:0] digit;

    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            digit <= DIGIT_FIRST;
        end else if (advance) begin
            digit <= (digit == DIGIT_LAST) ? DIGIT_FIRST : digit + 8'd1;
        end
    end

    always_comb begin
        pub_msg.data = '0;

        // Length word, little endian
        pub_msg.data[7:0]   = PUB_STRLEN;
        pub_msg.data[31:8]  = 24'd0;

        // First character of the text sits in the top byte of PUB_TEXT
        for (int k = 0; k < PUB_TEXT_LEN; k++) begin
            pub_msg.data[8*(TEXT_BYTE+k) +: 8] = PUB_TEXT[8*(PUB_TEXT_LEN-1-k) +: 8];
        end

        pub_msg.data[8*DIGIT_BYTE +: 8] = digit;
        pub_msg.len = PUB_LEN;
    end

endmodule

// File: reset_sync.sv
// Reset synchronizer for the internal clock domain
// Asserts at once, releases on the third clock edge
`timescale 1ns/1ns

module reset_sync (
    input  logic clk_int,
    input  logic rst_n,
    output logic rst_n_int
);

    logic [2:0] sync_q;

    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 3'b000;
        end else begin
            sync_q <= {sync_q[1:0], 1'b1};
        end
    end

    assign rst_n_int = sync_q[2];

endmodule

// File: ros2_app_pkg.sv
// Shared constants, packed structs and AXI4-Lite channel types
// for the ROS 2 application node
package ros2_app_pkg;

    localparam int MAX_APP_DATA_LEN = 64;
    localparam int PUB_TEXT_LEN     = 16;

    localparam logic [8*PUB_TEXT_LEN-1:0] PUB_TEXT = "Hello from FPGA ";
    localparam logic [7:0] PUB_STRLEN = 8'd17;
    localparam logic [7:0] PUB_LEN    = 8'd21;

    // Register map
    localparam logic [7:0] REG_CTRL    = 8'h00;
    localparam logic [7:0] REG_PERIOD  = 8'h04;
    localparam logic [7:0] REG_STATUS  = 8'h08;
    localparam logic [7:0] REG_SUB_LEN = 8'h0C;
    localparam logic [7:0] BUF_BASE    = 8'h40;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef struct packed {
        logic [MAX_APP_DATA_LEN*8-1:0] data;
        logic [7:0]                    len;
    } pub_msg_t;

    typedef struct packed {
        logic       ce;
        logic       we;
        logic [5:0] addr;
        logic [7:0] wdata;
    } sub_wr_t;

    typedef struct packed {
        logic        pub_en;
        logic        sub_en;
        logic [31:0] period;
    } app_cfg_t;

    typedef struct packed {
        logic [15:0] pub_count;
        logic [15:0] sub_count;
        logic [7:0]  sub_len;
    } app_status_t;

    typedef struct packed {
        logic [7:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [7:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

endpackage

// File: ros2_app_top.sv
// Application side of the ROS 2 node: reset, registers,
// publish control, message builder and subscriber buffer
`timescale 1ns/1ns

module ros2_app_top import ros2_app_pkg::*; #(
    parameter int          BUF_DEPTH      = MAX_APP_DATA_LEN,
    parameter logic [31:0] DEFAULT_PERIOD = 32'd1_000_000
) (
    input  logic       clk_int,
    input  logic       rst_n,

    input  axil_req_t  axil_req,
    output axil_rsp_t  axil_rsp,

    output pub_msg_t   pub_msg,
    output logic       pub_req,
    output logic       pub_rel,
    input  logic       pub_grant,

    input  sub_wr_t    sub_wr,
    input  logic [7:0] sub_len,
    input  logic       sub_recv,

    output logic [3:0] leds
);

    logic        rst_n_int;
    app_cfg_t    cfg;
    app_status_t status;
    logic        advance;
    logic        sub_open;
    logic [3:0]  buf_raddr;
    logic [31:0] buf_rdata;

    reset_sync i_reset_sync (
        .clk_int   (clk_int),
        .rst_n     (rst_n),
        .rst_n_int (rst_n_int)
    );

    app_cfg_regs #(
        .DEFAULT_PERIOD (DEFAULT_PERIOD)
    ) i_app_cfg_regs (
        .clk_int   (clk_int),
        .rst_n     (rst_n_int),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .cfg       (cfg),
        .status    (status),
        .buf_raddr (buf_raddr),
        .buf_rdata (buf_rdata)
    );

    app_ctrl i_app_ctrl (
        .clk_int   (clk_int),
        .rst_n     (rst_n_int),
        .cfg       (cfg),
        .pub_grant (pub_grant),
        .pub_req   (pub_req),
        .pub_rel   (pub_rel),
        .advance   (advance),
        .sub_recv  (sub_recv),
        .sub_len   (sub_len),
        .sub_open  (sub_open),
        .status    (status)
    );

    pub_msg_gen i_pub_msg_gen (
        .clk_int (clk_int),
        .rst_n   (rst_n_int),
        .advance (advance),
        .pub_msg (pub_msg)
    );

    sub_msg_buffer #(
        .DEPTH (BUF_DEPTH)
    ) i_sub_msg_buffer (
        .clk_int  (clk_int),
        .rst_n    (rst_n_int),
        .sub_wr   (sub_wr),
        .sub_open (sub_open),
        .raddr    (buf_raddr),
        .rdata    (buf_rdata),
        .leds     (leds)
    );

endmodule

// File: sub_msg_buffer.sv
// Subscriber capture RAM with byte writes, word reads
// and the LED copy of byte 0
`timescale 1ns/1ns

module sub_msg_buffer import ros2_app_pkg::*; #(
    parameter int DEPTH = MAX_APP_DATA_LEN
) (
    input  logic        clk_int,
    input  logic        rst_n,
    input  sub_wr_t     sub_wr,
    input  logic        sub_open,
    input  logic [3:0]  raddr,
    output logic [31:0] rdata,
    output logic [3:0]  leds
);

    logic [7:0] mem [DEPTH];
    logic       wr_ok;
    logic [5:0] rbase;

    assign wr_ok = sub_wr.ce && sub_wr.we && sub_open;
    assign rbase = {raddr, 2'b00};

    always_ff @(posedge clk_int) begin
        if (wr_ok) begin
            mem[sub_wr.addr] <= sub_wr.wdata;
        end
    end

    // Synchronous word read, byte 0 in the low lane
    always_ff @(posedge clk_int) begin
        rdata <= {mem[rbase + 6'd3], mem[rbase + 6'd2],
                  mem[rbase + 6'd1], mem[rbase]};
    end

    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            leds <= 4'd0;
        end else if (wr_ok && sub_wr.addr == 6'd0) begin
            leds <= sub_wr.wdata[3:0];
        end
    end

    a_wr_in_range: assert property (@(posedge clk_int) disable iff (!rst_n)
        wr_ok |-> (int'(sub_wr.addr) < DEPTH));

endmodule

// File: tb_ros2_app.sv
// Directed testbench for the ROS 2 application node
// Plays the AXI4-Lite master and the ROS 2 protocol engine
`timescale 1ns/1ns

module tb_ros2_app import ros2_app_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int PERIOD     = 20;
    localparam int WAIT_LIMIT = 400;
    localparam int NUM_PUB    = 12;
    localparam int NUM_SUB    = 24;

    // Registers 2000, publishing 6000, publish gate 2000, subscribing 4000,
    // subscribe gate 3000, back-pressure 3000
    localparam int BUDGET_CYCLES = 2000 + 6000 + 2000 + 4000 + 3000 + 3000;

    logic        clk_int;
    logic        rst_n;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    pub_msg_t    pub_msg;
    logic        pub_req;
    logic        pub_rel;
    logic        pub_grant;
    sub_wr_t     sub_wr;
    logic [7:0]  sub_len;
    logic        sub_recv;
    logic [3:0]  leds;
    integer      seed;
    logic [7:0]  sub_bytes [NUM_SUB];

    ros2_app_top #(
        .DEFAULT_PERIOD (PERIOD)
    ) i_ros2_app_top (
        .clk_int   (clk_int),
        .rst_n     (rst_n),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .pub_msg   (pub_msg),
        .pub_req   (pub_req),
        .pub_rel   (pub_rel),
        .pub_grant (pub_grant),
        .sub_wr    (sub_wr),
        .sub_len   (sub_len),
        .sub_recv  (sub_recv),
        .leds      (leds)
    );

    always #(CLK_PERIOD / 2) clk_int = ~clk_int;

    task automatic fail_run();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    // Outputs are sampled and inputs driven 2 ns after each rising edge
    task automatic next_cycle();
        @(posedge clk_int);
        #2;
    endtask

    task automatic count_wait(inout int n, input string what);
        next_cycle();
        n++;
        if (n > WAIT_LIMIT) begin
            $display("Timeout waiting for %s", what);
            fail_run();
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_leds(input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns leds: got 0x%h, expected 0x%h", $time, got, exp);
            fail_run();
        end
    endtask

    task automatic check_pub_msg(input pub_msg_t got, input pub_msg_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns pub_msg: got %h, expected %h", $time, got, exp);
            fail_run();
        end
    endtask

    task automatic check_status(input app_status_t got, input app_status_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns status (pub/sub/len): got %0d/%0d/%0d, expected %0d/%0d/%0d",
                     $time, got.pub_count, got.sub_count, got.sub_len,
                     exp.pub_count, exp.sub_count, exp.sub_len);
            fail_run();
        end
    endtask

    // Length word 17, the text, then the digit; 21 bytes in all
    function automatic pub_msg_t expected_pub_msg(input int n);
        pub_msg_t m;
        string    txt = "Hello from FPGA ";
        m = '0;
        m.data[7:0] = 8'd17;
        for (int k = 0; k < 16; k++) begin
            m.data[8*(4+k) +: 8] = txt[k];
        end
        m.data[8*20 +: 8] = 8'h30 + 8'(n % 10);
        m.len = 8'd21;
        return m;
    endfunction

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        int n;
        axil_req.awaddr  = addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = strb;
        axil_req.wvalid  = 1'b1;
        axil_req.bready  = 1'b1;
        n = 0;
        while (!(axil_rsp.awready && axil_rsp.wready)) count_wait(n, "awready and wready");
        next_cycle();
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        n = 0;
        while (!axil_rsp.bvalid) count_wait(n, "bvalid");
        check_word("bresp", 32'(axil_rsp.bresp), 32'(AXI_RESP_OKAY));
        next_cycle();
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
        int n;
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        axil_req.rready  = 1'b1;
        n = 0;
        while (!axil_rsp.arready) count_wait(n, "arready");
        next_cycle();
        axil_req.arvalid = 1'b0;
        n = 0;
        while (!axil_rsp.rvalid) count_wait(n, "rvalid");
        data = axil_rsp.rdata;
        check_word("rresp", 32'(axil_rsp.rresp), 32'(AXI_RESP_OKAY));
        next_cycle();
        axil_req.rready = 1'b0;
    endtask

    task automatic read_status(output app_status_t st);
        logic [31:0] w;
        axil_read(REG_STATUS, w);
        st.pub_count = w[15:0];
        st.sub_count = w[31:16];
        axil_read(REG_SUB_LEN, w);
        st.sub_len = w[7:0];
    endtask

    task automatic expect_status(input int pubs, input int subs, input int len);
        app_status_t got;
        app_status_t exp;
        read_status(got);
        exp.pub_count = 16'(pubs);
        exp.sub_count = 16'(subs);
        exp.sub_len   = 8'(len);
        check_status(got, exp);
    endtask

    task automatic wait_for_req();
        int n;
        n = 0;
        while (!pub_req) count_wait(n, "pub_req");
    endtask

    // Engine side holds the grant off, then grants and expects one release cycle
    task automatic serve_grant(input int delay, input pub_msg_t exp);
        for (int i = 0; i < delay; i++) begin
            next_cycle();
            check_word("pub_req", 32'(pub_req), 32'd1);
            check_word("pub_rel", 32'(pub_rel), 32'd0);
            check_pub_msg(pub_msg, exp);
        end
        pub_grant = 1'b1;
        next_cycle();
        pub_grant = 1'b0;
        check_word("pub_req", 32'(pub_req), 32'd0);
        check_word("pub_rel", 32'(pub_rel), 32'd1);
        next_cycle();
        check_word("pub_rel", 32'(pub_rel), 32'd0);
    endtask

    task automatic check_buffer(input logic [7:0] fill [NUM_SUB]);
        logic [31:0] w;
        for (int i = 0; i < NUM_SUB / 4; i++) begin
            axil_read(BUF_BASE + 8'(4 * i), w);
            check_word("buffer word", w,
                       {fill[4*i+3], fill[4*i+2], fill[4*i+1], fill[4*i]});
        end
    endtask

    task automatic reset_and_regs();
        logic [31:0] w;
        check_word("pub_req", 32'(pub_req), 32'd0);
        check_word("pub_rel", 32'(pub_rel), 32'd0);
        check_word("awready", 32'(axil_rsp.awready), 32'd0);
        check_word("wready", 32'(axil_rsp.wready), 32'd0);
        check_word("bvalid", 32'(axil_rsp.bvalid), 32'd0);
        check_word("arready", 32'(axil_rsp.arready), 32'd0);
        check_word("rvalid", 32'(axil_rsp.rvalid), 32'd0);
        check_leds(leds, 4'd0);
        check_pub_msg(pub_msg, expected_pub_msg(0));
        expect_status(0, 0, 0);
        axil_read(REG_CTRL, w);
        check_word("REG_CTRL", w, 32'd0);
        axil_read(REG_PERIOD, w);
        check_word("REG_PERIOD", w, 32'(PERIOD));
        axil_write(REG_PERIOD, 32'h1234_5678, 4'b1111);
        axil_read(REG_PERIOD, w);
        check_word("REG_PERIOD", w, 32'h1234_5678);
        // Lanes 0 and 2 only
        axil_write(REG_PERIOD, 32'hAABB_CCDD, 4'b0101);
        axil_read(REG_PERIOD, w);
        check_word("REG_PERIOD", w, 32'h12BB_56DD);
        axil_write(REG_PERIOD, 32'(PERIOD), 4'b1111);
        axil_write(REG_STATUS, 32'hFFFF_FFFF, 4'b1111);
        axil_read(8'h10, w);
        check_word("unmapped read", w, 32'd0);
        expect_status(0, 0, 0);
    endtask

    task automatic publish_sequence();
        int delay;
        axil_write(REG_CTRL, 32'd1, 4'b0001);
        for (int n = 0; n < NUM_PUB; n++) begin
            wait_for_req();
            check_pub_msg(pub_msg, expected_pub_msg(n));
            delay = $unsigned($random(seed)) % 8;
            serve_grant(delay, expected_pub_msg(n));
        end
        axil_write(REG_CTRL, 32'd0, 4'b0001);
        expect_status(NUM_PUB, 0, 0);
    endtask

    task automatic publish_gate();
        for (int i = 0; i < 5 * PERIOD; i++) begin
            next_cycle();
            check_word("pub_req", 32'(pub_req), 32'd0);
        end
        expect_status(NUM_PUB, 0, 0);
    endtask

    task automatic drive_sub_message(input logic [7:0] fill [NUM_SUB], input logic [7:0] len);
        for (int i = 0; i < NUM_SUB; i++) begin
            sub_wr = '{ce: 1'b1, we: 1'b1, addr: 6'(i), wdata: fill[i]};
            next_cycle();
        end
        sub_wr = '0;
        next_cycle();
        sub_len  = len;
        sub_recv = 1'b1;
        next_cycle();
        sub_recv = 1'b0;
        next_cycle();
    endtask

    task automatic subscribe_capture();
        for (int i = 0; i < NUM_SUB; i++) begin
            sub_bytes[i] = 8'($random(seed));
        end
        axil_write(REG_CTRL, 32'd2, 4'b0001);
        drive_sub_message(sub_bytes, 8'(NUM_SUB));
        check_leds(leds, sub_bytes[0][3:0]);
        check_buffer(sub_bytes);
        expect_status(NUM_PUB, 1, NUM_SUB);
    endtask

    task automatic subscribe_gate();
        logic [7:0] other [NUM_SUB];
        for (int i = 0; i < NUM_SUB; i++) begin
            other[i] = ~sub_bytes[i];
        end
        axil_write(REG_CTRL, 32'd0, 4'b0001);
        drive_sub_message(other, 8'd7);
        check_leds(leds, sub_bytes[0][3:0]);
        check_buffer(sub_bytes);
        expect_status(NUM_PUB, 1, NUM_SUB);
    endtask

    task automatic grant_back_pressure();
        axil_write(REG_CTRL, 32'd1, 4'b0001);
        wait_for_req();
        check_pub_msg(pub_msg, expected_pub_msg(NUM_PUB));
        // Clearing pub_en must not withdraw the raised request
        axil_write(REG_CTRL, 32'd0, 4'b0001);
        serve_grant(200, expected_pub_msg(NUM_PUB));
        expect_status(NUM_PUB + 1, 1, NUM_SUB);
    endtask

    initial begin
        #(BUDGET_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles", BUDGET_CYCLES);
        fail_run();
    end

    initial begin
        seed      = 32'h3857;
        clk_int   = 1'b0;
        rst_n     = 1'b0;
        axil_req  = '0;
        pub_grant = 1'b0;
        sub_wr    = '0;
        sub_len   = 8'd0;
        sub_recv  = 1'b0;
        repeat (4) @(posedge clk_int);
        #2;
        rst_n = 1'b1;
        repeat (5) next_cycle();

        reset_and_regs();
        publish_sequence();
        publish_gate();
        subscribe_capture();
        subscribe_gate();
        grant_back_pressure();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
